// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

  localparam int SCLK_HALF = 4;  // Clock cycles per SCLK half period
  localparam int RD_GAP    = 32; // Deselect cycles between header and reply
  localparam int HDR_BITS  = 4;
  localparam int CMD_BITS  = 12;
  localparam int DATA_BITS = 8;

  localparam int SCLK_CNT_W = $clog2(SCLK_HALF);
  localparam int BIT_CNT_W  = $clog2(CMD_BITS);
  localparam int GAP_CNT_W  = $clog2(RD_GAP);

  localparam logic [3:0] REG_CMD    = 4'h0;
  localparam logic [3:0] REG_STATUS = 4'h4;
  localparam logic [3:0] REG_RDATA  = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef struct packed {
    spi_op_e    op;
    logic [2:0] addr;
    logic [7:0] data;
  } spi_cmd_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_GAP,
    ST_RECV,
    ST_DONE
  } spi_state_e;

  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// File: spi_sclk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic tick
);
  import spi_pkg::*;

  localparam logic [SCLK_CNT_W-1:0] RELOAD = SCLK_CNT_W'(SCLK_HALF - 1);

  logic [SCLK_CNT_W-1:0] cnt;

  // Counts down from SCLK_HALF-1 so a tick lands every SCLK_HALF cycles
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt <= RELOAD;
    else if (!sclk_en || (cnt == '0))
      cnt <= RELOAD; // Held at reload between frames
    else
      cnt <= cnt - 1'b1;
  end

  assign tick = sclk_en && (cnt == '0);

endmodule

`default_nettype wire

// File: spi_cmd_engine.sv
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_engine (
  input  logic                          clk,
  input  logic                          rst_n,
  input  spi_pkg::spi_cmd_t             cmd,
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  output logic                          busy,
  output logic                          sclk_en,
  input  logic                          tick,
  output spi_pkg::spi_pins_t            spi,
  input  logic                          miso,
  output logic                          rd_valid,
  output logic [spi_pkg::DATA_BITS-1:0] rd_data
);
  import spi_pkg::*;

  spi_state_e           state;
  spi_op_e              op_q;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [BIT_CNT_W-1:0] last_idx;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic [CMD_BITS-1:0]  tx_sr;
  logic [DATA_BITS-1:0] rx_sr;
  logic                 accept;
  logic                 rise_tick;
  logic                 fall_tick;

  assign accept    = cmd_valid && cmd_ready;
  assign cmd_ready = (state == ST_IDLE);
  assign busy      = (state != ST_IDLE) || accept;
  assign rise_tick = tick && !spi.sclk;
  assign fall_tick = tick && spi.sclk;
  assign rd_valid  = (state == ST_DONE) && (op_q == OP_READ);
  assign rd_data   = rx_sr;

  // Frame length depends on phase and opcode
  always_comb
  begin
    if (state == ST_RECV)
      last_idx = BIT_CNT_W'(DATA_BITS - 1);
    else if (op_q == OP_WRITE)
      last_idx = BIT_CNT_W'(CMD_BITS - 1);
    else
      last_idx = BIT_CNT_W'(HDR_BITS - 1); // Read header only
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      op_q     <= OP_READ;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
      sclk_en  <= 1'b0;
      spi.sclk <= 1'b0;
      spi.cs_n <= 1'b1;
      spi.mosi <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            op_q     <= cmd.op;
            bit_cnt  <= '0;
            sclk_en  <= 1'b1;
            spi.cs_n <= 1'b0;
            spi.mosi <= cmd[CMD_BITS-1]; // MSB ready at cs_n fall
            state    <= ST_SEND;
          end
        end
        ST_SEND:
        begin
          if (tick)
            spi.sclk <= ~spi.sclk;
          if (fall_tick)
          begin
            if (bit_cnt == last_idx)
            begin
              sclk_en  <= 1'b0;
              spi.cs_n <= 1'b1;
              spi.mosi <= 1'b0;
              if (op_q == OP_WRITE)
                state <= ST_DONE;
              else
              begin
                gap_cnt <= GAP_CNT_W'(RD_GAP - 1);
                state   <= ST_GAP;
              end
            end
            else
            begin
              bit_cnt  <= bit_cnt + 1'b1;
              spi.mosi <= tx_sr[CMD_BITS-2]; // Next bit on falling edge
            end
          end
        end
        ST_GAP:
        begin
          if (gap_cnt == '0)
          begin
            bit_cnt  <= '0;
            sclk_en  <= 1'b1;
            spi.cs_n <= 1'b0; // Reselect for the reply
            state    <= ST_RECV;
          end
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        ST_RECV:
        begin
          if (tick)
            spi.sclk <= ~spi.sclk;
          if (fall_tick)
          begin
            if (bit_cnt == last_idx)
            begin
              sclk_en  <= 1'b0;
              spi.cs_n <= 1'b1;
              state    <= ST_DONE;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_DONE:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      tx_sr <= cmd;
    else if ((state == ST_SEND) && fall_tick)
      tx_sr <= {tx_sr[CMD_BITS-2:0], 1'b0};
    if ((state == ST_RECV) && rise_tick)
      rx_sr <= {rx_sr[DATA_BITS-2:0], miso}; // Sample on SCLK rise
  end

  a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == ST_IDLE) |-> spi.cs_n)
    else $error("cs_n low while sequencer idle");

  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_valid && !cmd_ready) |=> $stable(cmd))
    else $error("cmd changed while waiting for cmd_ready");

endmodule

`default_nettype wire

// File: spi_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module spi_axil_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  spi_pkg::axil_req_t            axil_req,
  output spi_pkg::axil_rsp_t            axil_rsp,
  output spi_pkg::spi_cmd_t             cmd,
  output logic                          cmd_valid,
  input  logic                          cmd_ready,
  input  logic                          busy,
  input  logic                          rd_valid,
  input  logic [spi_pkg::DATA_BITS-1:0] rd_data
);
  import spi_pkg::*;

  logic                 wr_hs;
  logic                 rd_hs;
  logic                 cmd_err;
  logic                 cmd_load;
  logic                 bvalid_q;
  logic [1:0]           bresp_q;
  logic                 rvalid_q;
  logic [31:0]          rdata_q;
  logic [31:0]          rd_mux;
  logic                 rdata_valid_q;
  logic [DATA_BITS-1:0] rbyte_q;

  assign wr_hs    = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_hs    = axil_req.arvalid && !rvalid_q;
  assign cmd_err  = (axil_req.awaddr == REG_CMD) && (cmd_valid || busy); // One command only
  assign cmd_load = wr_hs && (axil_req.awaddr == REG_CMD) && !cmd_err;

  always_comb
  begin
    case (axil_req.araddr)
      REG_STATUS: rd_mux = {30'd0, rdata_valid_q, busy || cmd_valid};
      REG_RDATA:  rd_mux = {{(32 - DATA_BITS){1'b0}}, rbyte_q};
      default:    rd_mux = '0;
    endcase
  end

  always_comb
  begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = !rvalid_q;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = RESP_OKAY;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bvalid_q      <= 1'b0;
      bresp_q       <= RESP_OKAY;
      rvalid_q      <= 1'b0;
      cmd_valid     <= 1'b0;
      rdata_valid_q <= 1'b0;
    end
    else
    begin
      if (wr_hs)
      begin
        bvalid_q <= 1'b1;
        bresp_q  <= cmd_err ? RESP_SLVERR : RESP_OKAY;
      end
      else if (axil_req.bready)
        bvalid_q <= 1'b0;

      if (cmd_load)
        cmd_valid <= 1'b1;
      else if (cmd_ready)
        cmd_valid <= 1'b0; // Taken by the sequencer

      if (rd_hs)
        rvalid_q <= 1'b1;
      else if (axil_req.rready)
        rvalid_q <= 1'b0;

      if (rd_valid)
        rdata_valid_q <= 1'b1; // New byte wins over a clearing read
      else if (rd_hs && (axil_req.araddr == REG_RDATA))
        rdata_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_load)
      cmd <= spi_cmd_t'(axil_req.wdata[CMD_BITS-1:0]);
    if (rd_hs)
      rdata_q <= rd_mux;
    if (rd_valid)
      rbyte_q <= rd_data;
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid_q && !axil_req.bready) |=> bvalid_q)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid_q && !axil_req.rready) |=> rvalid_q)
    else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

// File: spi_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_top (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::axil_req_t axil_req,
  output spi_pkg::axil_rsp_t axil_rsp,
  output spi_pkg::spi_pins_t spi,
  input  logic               miso
);
  import spi_pkg::*;

  spi_cmd_t             cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 busy;
  logic                 rd_valid;
  logic [DATA_BITS-1:0] rd_data;
  logic                 sclk_en;
  logic                 tick;

  spi_axil_regs spi_axil_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .busy      (busy),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  spi_cmd_engine spi_cmd_engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .busy      (busy),
    .sclk_en   (sclk_en),
    .tick      (tick),
    .spi       (spi),
    .miso      (miso),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  spi_sclk_gen spi_sclk_gen_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .sclk_en (sclk_en),
    .tick    (tick)
  );

endmodule

`default_nettype wire

// File: spi_ctrl_checker.sv
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::axil_req_t axil_req,
  input  spi_pkg::axil_rsp_t axil_rsp,
  input  spi_pkg::spi_pins_t spi,
  input  logic               miso,
  input  logic               exp_push,
  input  spi_pkg::spi_cmd_t  exp_cmd,
  output int                 err_cnt
);
  import spi_pkg::*;

  spi_cmd_t   cmd_q [$];
  spi_cmd_t   cur;
  logic [7:0] model [8];
  logic       prev_sclk;
  logic       prev_cs_n;
  logic [11:0] mo_sr;
  logic [7:0] mi_sr;
  int         edges;
  logic       in_reply;
  logic [2:0] last_rd_addr;
  logic [3:0] ar_addr_q;
  int         frame_errs;
  int         axi_errs;

  assign err_cnt = frame_errs + axi_errs;

  initial
  begin
    frame_errs = 0;
    axi_errs = 0;
    prev_sclk = 1'b0;
    prev_cs_n = 1'b1;
    in_reply = 1'b0;
    last_rd_addr = '0;
    edges = 0;
    for (int i = 0; i < 8; i++)
      model[i] = 8'(i * 8'h1d) ^ 8'ha5;
  end

  always @(posedge clk)
  begin
    if (exp_push)
      cmd_q.push_back(exp_cmd);
    if (axil_req.arvalid && axil_rsp.arready)
      ar_addr_q <= axil_req.araddr;
    if (axil_rsp.rvalid && axil_req.rready && axil_rsp.rresp != RESP_OKAY)
    begin
      axi_errs++;
      $display("FAILED at %0t: read response %02b, expected OKAY", $time,
               axil_rsp.rresp);
    end
    if (axil_rsp.rvalid && axil_req.rready && ar_addr_q == REG_RDATA &&
        axil_rsp.rdata[7:0] != model[last_rd_addr])
    begin
      axi_errs++;
      $display("FAILED at %0t: RDATA %02h, device %0d holds %02h", $time,
               axil_rsp.rdata[7:0], last_rd_addr, model[last_rd_addr]);
    end
  end

  // Frame decoder
  always @(spi.sclk or spi.cs_n)
  begin
    if (rst_n && prev_cs_n && !spi.cs_n)
    begin
      edges = 0;
      mo_sr = '0;
      mi_sr = '0;
    end
    if (rst_n && !spi.cs_n && !prev_sclk && spi.sclk)
    begin
      mo_sr = {mo_sr[10:0], spi.mosi};
      mi_sr = {mi_sr[6:0], miso};
      edges++;
    end
    if (rst_n && !prev_cs_n && spi.cs_n)
    begin
      if (in_reply)
      begin
        in_reply = 1'b0;
        if (edges != DATA_BITS || mi_sr != model[last_rd_addr])
        begin
          frame_errs++;
          $display("FAILED at %0t: reply %0d edges, byte %02h", $time, edges, mi_sr);
        end
      end
      else if (cmd_q.size() == 0)
      begin
        frame_errs++;
        $display("FAILED at %0t: frame with no command issued", $time);
      end
      else
      begin
        cur = cmd_q.pop_front();
        if (cur.op == OP_WRITE)
        begin
          if (edges != CMD_BITS || mo_sr != 12'(cur))
          begin
            frame_errs++;
            $display("FAILED at %0t: write frame %03h/%0d edges, expected %03h",
                     $time, mo_sr, edges, 12'(cur));
          end
          model[cur.addr] = cur.data;
        end
        else
        begin
          if (edges != HDR_BITS || mo_sr[3:0] != {1'b0, cur.addr})
          begin
            frame_errs++;
            $display("FAILED at %0t: read header %01h/%0d edges", $time, mo_sr[3:0], edges);
          end
          last_rd_addr = cur.addr;
          in_reply = 1'b1;
        end
      end
    end
    prev_sclk = spi.sclk;
    prev_cs_n = spi.cs_n;
  end

endmodule

`default_nettype wire

// File: tb_spi_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_spi_ctrl;
  import spi_pkg::*;

  localparam int TIMEOUT = 2000;

  logic       clk;
  logic       rst_n;
  axil_req_t  req;
  axil_rsp_t  rsp;
  spi_pins_t  spi;
  logic       miso;
  logic       exp_push;
  spi_cmd_t   exp_cmd;
  int         chk_errs;
  int         tb_errs;
  int         err_mark;
  int         test_cnt;
  logic [31:0] lfsr_q;
  logic [7:0] exp_mem [8];  // Expected device contents
  logic [7:0] dev_mem [8];  // Device model storage
  logic       prev_sclk;
  logic       prev_cs_n;
  logic [11:0] dev_sr;
  int         dev_bits;
  logic       reply_pend;
  logic       reply_act;
  logic [2:0] reply_addr;
  int         reply_bit;

  spi_ctrl_top spi_ctrl_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (req),
    .axil_rsp (rsp),
    .spi      (spi),
    .miso     (miso)
  );

  spi_ctrl_checker spi_ctrl_checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (req),
    .axil_rsp (rsp),
    .spi      (spi),
    .miso     (miso),
    .exp_push (exp_push),
    .exp_cmd  (exp_cmd),
    .err_cnt  (chk_errs)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Mode 0 SPI device model
  always @(spi.sclk or spi.cs_n)
  begin
    if (prev_cs_n && !spi.cs_n)
    begin
      dev_bits = 0;
      dev_sr = '0;
      reply_act = reply_pend;
      reply_pend = 1'b0;
      if (reply_act)
      begin
        miso = dev_mem[reply_addr][7]; // First bit at select
        reply_bit = 6;
      end
    end
    if (!spi.cs_n && !prev_sclk && spi.sclk)
    begin
      dev_sr = {dev_sr[10:0], spi.mosi};
      dev_bits++;
    end
    if (!spi.cs_n && prev_sclk && !spi.sclk && reply_act && reply_bit >= 0)
    begin
      miso = dev_mem[reply_addr][reply_bit];
      reply_bit--;
    end
    if (!prev_cs_n && spi.cs_n)
    begin
      if (reply_act)
        reply_act = 1'b0;
      else if (dev_bits == CMD_BITS && dev_sr[11])
        dev_mem[dev_sr[10:8]] = dev_sr[7:0];
      else if (dev_bits == HDR_BITS && !dev_sr[3])
      begin
        reply_pend = 1'b1;
        reply_addr = dev_sr[2:0];
      end
    end
    prev_sclk = spi.sclk;
    prev_cs_n = spi.cs_n;
  end

  task automatic report_mismatch(input string msg);
    tb_errs++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    tb_errs++;
    $display("Timed out waiting for %s at %0t", what, $time);
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int t;
    int d;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    t = 0;
    do
    begin
      @(posedge clk);
      t++;
    end while (!rsp.awready && t < TIMEOUT);
    if (!rsp.awready)
      report_timeout("awready");
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    d = take_bits(2); // Random bready delay
    repeat (d)
    begin
      @(posedge clk);
      #1;
    end
    req.bready = 1'b1;
    t = 0;
    do
    begin
      @(posedge clk);
      t++;
    end while (!rsp.bvalid && t < TIMEOUT);
    if (!rsp.bvalid)
      report_timeout("bvalid");
    resp = rsp.bresp;
    #1;
    req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    int t;
    int d;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    t = 0;
    do
    begin
      @(posedge clk);
      t++;
    end while (!rsp.arready && t < TIMEOUT);
    if (!rsp.arready)
      report_timeout("arready");
    #1;
    req.arvalid = 1'b0;
    d = take_bits(2);
    repeat (d)
    begin
      @(posedge clk);
      #1;
    end
    req.rready = 1'b1;
    t = 0;
    do
    begin
      @(posedge clk);
      t++;
    end while (!rsp.rvalid && t < TIMEOUT);
    if (!rsp.rvalid)
      report_timeout("rvalid");
    data = rsp.rdata;
    #1;
    req.rready = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int t;
    t = 0;
    do
    begin
      axi_read(REG_STATUS, st);
      t++;
    end while (st[0] && t < 200);
    if (st[0])
      report_timeout("sequencer idle");
  endtask

  task automatic push_expected(input spi_cmd_t c);
    exp_cmd  = c;
    exp_push = 1'b1;
    @(posedge clk);
    #1;
    exp_push = 1'b0;
  endtask

  task automatic write_device(input logic [2:0] addr, input logic [7:0] data);
    spi_cmd_t c;
    logic [1:0] resp;
    c = {OP_WRITE, addr, data};
    push_expected(c);
    axi_write(REG_CMD, 32'(c), resp);
    if (resp != RESP_OKAY)
      report_mismatch("write command refused");
    exp_mem[addr] = data;
    wait_idle();
  endtask

  task automatic read_device(input logic [2:0] addr);
    spi_cmd_t c;
    logic [1:0] resp;
    logic [31:0] v;
    c = {OP_READ, addr, 8'(take_bits(8))}; // Data bits not sent
    push_expected(c);
    axi_write(REG_CMD, 32'(c), resp);
    if (resp != RESP_OKAY)
      report_mismatch("read command refused");
    wait_idle();
    axi_read(REG_STATUS, v);
    if (!v[1])
      report_mismatch("rdata_valid not set after read");
    axi_read(REG_RDATA, v);
    if (v[7:0] != exp_mem[addr])
      report_mismatch($sformatf("rdata %02h, expected %02h", v[7:0], exp_mem[addr]));
    axi_read(REG_STATUS, v);
    if (v[1])
      report_mismatch("rdata_valid not cleared by RDATA read");
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = tb_errs + chk_errs - err_mark;
    test_cnt++;
    $display("Test %0d %s: %s (%0d errors)", test_cnt, name, errs == 0 ? "ok" : "bad", errs);
    err_mark = tb_errs + chk_errs;
  endtask

  initial
  begin
    logic [31:0] v;
    logic [1:0] resp;
    req = '0;
    miso = 1'b0;
    exp_push = 1'b0;
    exp_cmd = '0;
    tb_errs = 0;
    err_mark = 0;
    test_cnt = 0;
    lfsr_q = 32'hab35_09eb;
    prev_sclk = 1'b0;
    prev_cs_n = 1'b1;
    dev_sr = '0;
    dev_bits = 0;
    reply_pend = 1'b0;
    reply_act = 1'b0;
    reply_addr = '0;
    reply_bit = 0;
    for (int i = 0; i < 8; i++)
    begin
      exp_mem[i] = 8'(i * 8'h1d) ^ 8'ha5;
      dev_mem[i] = 8'(i * 8'h1d) ^ 8'ha5;
    end
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    if (!spi.cs_n || spi.sclk || spi.mosi)
      report_mismatch("SPI pins not idle after reset");
    axi_read(REG_STATUS, v);
    if (v != 32'd0)
      report_mismatch($sformatf("STATUS %08h after reset", v));
    end_test("reset");

    repeat (8)
      write_device(3'(take_bits(3)), 8'(take_bits(8)));
    end_test("writes");

    repeat (4)
      read_device(3'(take_bits(3)));
    end_test("reads");

    begin
      spi_cmd_t c;
      c = {OP_WRITE, 3'(take_bits(3)), 8'(take_bits(8))};
      push_expected(c);
      axi_write(REG_CMD, 32'(c), resp);
      if (resp != RESP_OKAY)
        report_mismatch("first command refused");
      exp_mem[c.addr] = c.data;
      axi_write(REG_CMD, 32'h0000_0fff, resp); // Dropped while busy
      if (resp != RESP_SLVERR)
        report_mismatch("second command while busy not refused");
      wait_idle();
    end
    end_test("busy refusal");

    repeat (20)
    begin
      if (take_bits(1) != 0)
        write_device(3'(take_bits(3)), 8'(take_bits(8)));
      else
        read_device(3'(take_bits(3)));
    end
    end_test("mixed traffic");

    repeat (20) @(posedge clk);
    $display("Tests %0d, errors %0d", test_cnt, tb_errs + chk_errs);
    if (tb_errs + chk_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
spi_pkg.sv
spi_sclk_gen.sv
spi_cmd_engine.sv
spi_axil_regs.sv
spi_ctrl_top.sv
spi_ctrl_checker.sv
tb_spi_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_ctrl
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module spi_ctrl_top -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
